// File: design/adc_if_pkg.sv
/*
 * register map, bus widths and conversion timing constants
 * shared by the ADC capture core
 */

package adc_if_pkg;

  // register port widths
  localparam int reg_addr_width = 4;
  localparam int reg_data_width = 32;

  // ------------------------------
  // register map
  // ------------------------------
  // bit 0 enables periodic conversion
  localparam logic [reg_addr_width-1:0] addr_control = 4'h0;
  // conversion period in clock cycles
  localparam logic [reg_addr_width-1:0] addr_period  = 4'h4;
  // bit 0 sticky overflow, write 1 to clear
  localparam logic [reg_addr_width-1:0] addr_status  = 4'h8;
  // read-only count of delivered samples
  localparam logic [reg_addr_width-1:0] addr_count   = 4'hc;

  // ------------------------------
  // conversion timing
  // ------------------------------
  // cycles from cnv to the first gated edge
  localparam int conv_cycles      = 6;
  // period register value after reset
  localparam int default_period   = 32;
  // extra idle cycles kept after the gate window
  localparam int min_period_slack = 4;

endpackage

// File: design/adc_cnv_timer.sv
/*
 * conversion timer: period counter with cnv strobe
 * and the clock gate window for the serial data lanes
 */

`timescale 1ns/100ps

module adc_cnv_timer
  import adc_if_pkg::*;
#(
  parameter int resolution = 18,
  parameter int two_lanes  = 1
) (
  input  logic        s_axi_aclk,
  input  logic        reset,
  input  logic        enable,
  input  logic [31:0] period,
  output logic        cnv,
  output logic        clk_gate
);

  // gated edges per sample on each lane
  localparam int bits_per_lane = (two_lanes != 0) ? (resolution + 1) / 2 : resolution;
  // shortest period that still fits conversion, readout and slack
  localparam int min_period = conv_cycles + bits_per_lane + min_period_slack;
  localparam int gate_w = $clog2(bits_per_lane);

  localparam logic [31:0] min_period_w    = 32'(min_period);
  // gate opens at the edge closing this cycle
  localparam logic [31:0] gate_open_cycle = 32'(conv_cycles - 1);

  logic [31:0]       eff_period;
  logic [31:0]       cycle_cnt;
  logic              active;
  logic              period_end;
  logic              start;
  logic [gate_w-1:0] gate_left;

  // ------------------------------
  // period counter
  // ------------------------------

  // clamp the programmed period to the minimum
  assign eff_period = (period > min_period_w) ? period : min_period_w;

  // >= so that a period lowered mid-run still ends the current one
  assign period_end = active && (cycle_cnt >= eff_period - 32'd1);

  // a new conversion only starts from idle or at a period boundary
  assign start = enable && (!active || period_end);

  always_ff @(posedge s_axi_aclk) begin
    if (reset) begin
      active    <= 1'b0;
      cycle_cnt <= '0;
      cnv       <= 1'b0;
    end else begin
      // cnv is high in cycle 0 of each period
      cnv <= start;
      if (start) begin
        active    <= 1'b1;
        cycle_cnt <= '0;
      end else if (period_end) begin
        // enable dropped, the running period has now finished
        active    <= 1'b0;
        cycle_cnt <= '0;
      end else if (active) begin
        cycle_cnt <= cycle_cnt + 32'd1;
      end
    end
  end

  // ------------------------------
  // gate window
  // ------------------------------

  // high from cycle conv_cycles for exactly bits_per_lane cycles
  always_ff @(posedge s_axi_aclk) begin
    if (reset) begin
      clk_gate  <= 1'b0;
      gate_left <= '0;
    end else if (active && (cycle_cnt == gate_open_cycle)) begin
      clk_gate  <= 1'b1;
      gate_left <= gate_w'(bits_per_lane - 1);
    end else if (clk_gate) begin
      if (gate_left == '0) begin
        clk_gate <= 1'b0;
      end else begin
        gate_left <= gate_left - 1'b1;
      end
    end
  end

endmodule

// File: design/adc_lane_deser.sv
/*
 * lane deserializer: shifts one or two serial lanes in MSB first
 * and presents each finished sample with a one-cycle valid
 */

`timescale 1ns/100ps

module adc_lane_deser #(
  parameter int resolution = 18,
  parameter int two_lanes  = 1
) (
  input  logic                  s_axi_aclk,
  input  logic                  reset,
  input  logic                  clk_gate,
  input  logic                  da,
  input  logic                  db,
  output logic [resolution-1:0] adc_data,
  output logic                  adc_valid
);

  // gated edges per sample, 9 for 18 bits over two lanes
  localparam int bits_per_lane = (two_lanes != 0) ? (resolution + 1) / 2 : resolution;
  localparam int bit_w = $clog2(bits_per_lane);

  logic [resolution-1:0] shift_q;
  logic [resolution-1:0] shift_next;
  logic [bit_w-1:0]      bit_cnt;
  logic                  last_edge;

  // ------------------------------
  // lane packing
  // ------------------------------

  generate
    if (two_lanes != 0) begin : g_two_lanes
      // da holds the higher bit of each pair
      assign shift_next = {shift_q[resolution-3:0], da, db};
    end else begin : g_one_lane
      assign shift_next = {shift_q[resolution-2:0], da};
    end
  endgenerate

  // final gated edge of the window completes the sample
  assign last_edge = clk_gate && (bit_cnt == bit_w'(bits_per_lane - 1));

  // ------------------------------
  // sample assembly
  // ------------------------------

  // sample shift register and captured output word
  always_ff @(posedge s_axi_aclk) begin
    if (clk_gate) begin
      shift_q <= shift_next;
    end
    // take the word including the bits of the last edge
    if (last_edge) begin
      adc_data <= shift_next;
    end
  end

  // edge counter and valid strobe
  always_ff @(posedge s_axi_aclk) begin
    if (reset) begin
      bit_cnt   <= '0;
      adc_valid <= 1'b0;
    end else begin
      // valid lands in the cycle after the last gated edge
      adc_valid <= last_edge;
      if (last_edge) begin
        bit_cnt <= '0;
      end else if (clk_gate) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// File: design/adc_ctrl_regs.sv
/*
 * control register bank: enable, period, sticky overflow status
 * and delivered sample counter, with registered read data
 */

`timescale 1ns/100ps

module adc_ctrl_regs
  import adc_if_pkg::*;
(
  input  logic                      s_axi_aclk,
  input  logic                      reset,
  input  logic                      wr_en,
  input  logic                      rd_en,
  input  logic [reg_addr_width-1:0] reg_addr,
  input  logic [reg_data_width-1:0] wr_data,
  output logic [reg_data_width-1:0] rd_data,
  output logic                      rd_valid,
  input  logic                      adc_valid,
  input  logic                      adc_dovf,
  output logic                      enable,
  output logic [reg_data_width-1:0] period
);

  logic                      overflow;
  logic [reg_data_width-1:0] sample_count;
  logic                      wr_control;
  logic                      wr_period;
  logic                      wr_status;
  logic [reg_data_width-1:0] rd_mux;

  // ------------------------------
  // write decode
  // ------------------------------

  assign wr_control = wr_en && (reg_addr == addr_control);
  assign wr_period  = wr_en && (reg_addr == addr_period);
  // count is read-only, writes to it are dropped
  assign wr_status  = wr_en && (reg_addr == addr_status);

  always_ff @(posedge s_axi_aclk) begin
    if (reset) begin
      enable       <= 1'b0;
      period       <= reg_data_width'(default_period);
      overflow     <= 1'b0;
      sample_count <= '0;
    end else begin
      if (wr_control) begin
        enable <= wr_data[0];
      end
      if (wr_period) begin
        period <= wr_data;
      end
      // a new overflow wins over a clear in the same cycle
      if (adc_dovf) begin
        overflow <= 1'b1;
      end else if (wr_status && wr_data[0]) begin
        overflow <= 1'b0;
      end
      // one count per delivered sample
      if (adc_valid) begin
        sample_count <= sample_count + 1'b1;
      end
    end
  end

  // ------------------------------
  // read path
  // ------------------------------

  always_comb begin
    case (reg_addr)
      addr_control: rd_mux = {{(reg_data_width-1){1'b0}}, enable};
      addr_period:  rd_mux = period;
      addr_status:  rd_mux = {{(reg_data_width-1){1'b0}}, overflow};
      addr_count:   rd_mux = sample_count;
      // unmapped addresses read as zero
      default:      rd_mux = '0;
    endcase
  end

  // data one cycle after rd_en, held until the next read
  always_ff @(posedge s_axi_aclk) begin
    if (rd_en) begin
      rd_data <= rd_mux;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

// File: design/adc_capture_top.sv
/*
 * ADC capture core top level: conversion timer,
 * lane deserializer and control register bank
 */

`timescale 1ns/100ps

module adc_capture_top
  import adc_if_pkg::*;
#(
  parameter int resolution = 18,
  parameter int two_lanes  = 1
) (
  input  logic                      s_axi_aclk,
  input  logic                      reset,
  // register port
  input  logic                      wr_en,
  input  logic                      rd_en,
  input  logic [reg_addr_width-1:0] reg_addr,
  input  logic [reg_data_width-1:0] wr_data,
  output logic [reg_data_width-1:0] rd_data,
  output logic                      rd_valid,
  // serial lanes from the converter
  input  logic                      da,
  input  logic                      db,
  // downstream overflow strobe
  input  logic                      adc_dovf,
  // converter control
  output logic                      cnv,
  output logic                      clk_gate,
  // sample stream
  output logic [resolution-1:0]     adc_data,
  output logic                      adc_valid
);

  logic                      enable;
  logic [reg_data_width-1:0] period;

  // cnv strobe and gate window
  adc_cnv_timer #(
    .resolution (resolution),
    .two_lanes  (two_lanes)
  ) i_timer (
    .s_axi_aclk (s_axi_aclk),
    .reset      (reset),
    .enable     (enable),
    .period     (period),
    .cnv        (cnv),
    .clk_gate   (clk_gate)
  );

  // lane shift-in and sample output
  adc_lane_deser #(
    .resolution (resolution),
    .two_lanes  (two_lanes)
  ) i_deser (
    .s_axi_aclk (s_axi_aclk),
    .reset      (reset),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid)
  );

  // control and status registers
  adc_ctrl_regs i_regs (
    .s_axi_aclk (s_axi_aclk),
    .reset      (reset),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .reg_addr   (reg_addr),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .adc_valid  (adc_valid),
    .adc_dovf   (adc_dovf),
    .enable     (enable),
    .period     (period)
  );

endmodule

// File: testbench/adc_model.sv
/*
 * behavioral serial ADC: loads an incrementing sample on cnv
 * and shifts its bits out on the gated clock edges
 */

`timescale 1ns/100ps

module adc_model #(
  parameter int          resolution   = 18,
  parameter int          two_lanes    = 1,
  parameter logic [31:0] first_sample = 32'h0003_a5a5
) (
  input  logic s_axi_aclk,
  input  logic cnv,
  input  logic clk_gate,
  output logic da,
  output logic db
);

  // bits leaving the converter per gated edge
  localparam int step = (two_lanes != 0) ? 2 : 1;

  logic [resolution-1:0] shift_reg;
  logic [31:0]           next_value;
  logic                  load;
  logic                  shift;

  initial begin
    shift_reg  = '0;
    next_value = first_sample;
  end

  // control levels are taken mid-cycle, lanes change just after the edge
  always @(negedge s_axi_aclk) begin
    load  = cnv;
    shift = clk_gate;
    @(posedge s_axi_aclk);
    #5;
    if (load) begin
      // conversion result wraps at the converter width
      shift_reg  = next_value[resolution-1:0];
      next_value = next_value + 32'd1;
    end else if (shift) begin
      shift_reg = shift_reg << step;
    end
  end

  // MSB on da, the next bit down on db
  assign da = shift_reg[resolution-1];
  assign db = (two_lanes != 0) ? shift_reg[resolution-2] : 1'b0;

endmodule

// File: testbench/adc_capture_tb.sv
/*
 * testbench for the ADC capture core: clock, reset, register stimulus,
 * reference sample function, monitor with compare, and per-test report
 */

`timescale 1ns/100ps

module adc_capture_tb
  import adc_if_pkg::*;
#(
  parameter int resolution = 18,
  parameter int two_lanes  = 1
);

  localparam int bits_per_lane = (two_lanes != 0) ? (resolution + 1) / 2 : resolution;
  localparam int min_period    = conv_cycles + bits_per_lane + min_period_slack;
  localparam int default_eff   = (default_period > min_period) ? default_period : min_period;
  localparam int cnv_timeout   = 4 * default_eff + 20;
  localparam int drive_delay   = 5;

  logic                      s_axi_aclk;
  logic                      reset;
  logic                      wr_en;
  logic                      rd_en;
  logic [reg_addr_width-1:0] reg_addr;
  logic [reg_data_width-1:0] wr_data;
  logic [reg_data_width-1:0] rd_data;
  logic                      rd_valid;
  logic                      da;
  logic                      db;
  logic                      adc_dovf;
  logic                      cnv;
  logic                      clk_gate;
  logic [resolution-1:0]     adc_data;
  logic                      adc_valid;

  // monitor state
  int    cycle_no;
  int    last_cnv;
  int    last_latency;
  int    cnv_seen;
  int    gate_cycles;
  int    valid_seen;
  // run bookkeeping
  int    error_count;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  string test_name;
  integer seed;

  adc_capture_top #(
    .resolution (resolution),
    .two_lanes  (two_lanes)
  ) i_dut (
    .s_axi_aclk (s_axi_aclk),
    .reset      (reset),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .reg_addr   (reg_addr),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .da         (da),
    .db         (db),
    .adc_dovf   (adc_dovf),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid)
  );

  adc_model #(
    .resolution (resolution),
    .two_lanes  (two_lanes)
  ) i_adc (
    .s_axi_aclk (s_axi_aclk),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db)
  );

  // 40 ns clock
  initial s_axi_aclk = 1'b0;
  always #20 s_axi_aclk = ~s_axi_aclk;

  // ------------------------------
  // reference and reporting
  // ------------------------------

  // n-th sample after reset, wrapped to the converter width
  function automatic logic [resolution-1:0] expected_sample(input int n);
    logic [31:0] full;
    full = 32'h0003_a5a5 + 32'(n);
    return full[resolution-1:0];
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("error %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    error_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s: %s", test_name, what);
    error_count++;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    if (error_count != test_errors) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, error_count - test_errors);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // ------------------------------
  // monitor and compare
  // ------------------------------

  // mid-cycle sampling, all DUT outputs are settled here
  always @(negedge s_axi_aclk) begin
    cycle_no++;
    if (cnv) begin
      last_cnv = cycle_no;
      cnv_seen++;
    end
    if (clk_gate) begin
      gate_cycles++;
    end
    if (adc_valid) begin
      last_latency = cycle_no - last_cnv;
      if (adc_data !== expected_sample(valid_seen)) begin
        report_mismatch($sformatf("sample %0d", valid_seen), 32'(expected_sample(valid_seen)),
                        32'(adc_data));
      end
      valid_seen++;
    end
  end

  // ------------------------------
  // register and wait helpers
  // ------------------------------

  task automatic write_reg(input logic [reg_addr_width-1:0] addr,
                           input logic [reg_data_width-1:0] data);
    @(posedge s_axi_aclk);
    #drive_delay;
    wr_en    = 1'b1;
    reg_addr = addr;
    wr_data  = data;
    @(posedge s_axi_aclk);
    #drive_delay;
    wr_en = 1'b0;
  endtask

  task automatic read_reg(input logic [reg_addr_width-1:0] addr,
                          output logic [reg_data_width-1:0] data);
    int waited;
    @(posedge s_axi_aclk);
    #drive_delay;
    // rd_valid is a single-cycle pulse, low between reads
    if (rd_valid) report_mismatch("rd_valid before read", 0, 1);
    rd_en    = 1'b1;
    reg_addr = addr;
    @(posedge s_axi_aclk);
    #drive_delay;
    rd_en  = 1'b0;
    waited = 0;
    while (!rd_valid && waited < 8) begin
      @(posedge s_axi_aclk);
      #drive_delay;
      waited++;
    end
    if (!rd_valid) begin
      report_timeout("rd_valid never rose after a read");
    end
    data = rd_data;
  endtask

  // returns the monitor cycle of the next cnv pulse
  task automatic wait_cnv(output int at_cycle);
    int start_count;
    int waited;
    start_count = cnv_seen;
    waited      = 0;
    while (cnv_seen == start_count && waited < cnv_timeout) begin
      @(posedge s_axi_aclk);
      #drive_delay;
      waited++;
    end
    if (cnv_seen == start_count) begin
      report_timeout("no cnv pulse");
    end
    at_cycle = last_cnv;
  endtask

  task automatic wait_samples(input int target, input int limit);
    int waited;
    waited = 0;
    while (valid_seen < target && waited < limit) begin
      @(posedge s_axi_aclk);
      #drive_delay;
      waited++;
    end
    if (valid_seen < target) begin
      report_timeout($sformatf("only %0d of %0d samples arrived", valid_seen, target));
    end
  endtask

  // clear enable and let the running conversion deliver its sample
  task automatic stop_and_drain();
    int waited;
    write_reg(addr_control, 32'h0);
    repeat (2) @(posedge s_axi_aclk);
    #drive_delay;
    waited = 0;
    while (valid_seen != cnv_seen && waited < cnv_timeout) begin
      @(posedge s_axi_aclk);
      #drive_delay;
      waited++;
    end
    if (valid_seen != cnv_seen) begin
      report_timeout("conversion did not finish after disable");
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    logic [reg_data_width-1:0] rd_word;
    int t0;
    int t1;
    int gap;
    int cnv_mark;

    reset    = 1'b1;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    reg_addr = '0;
    wr_data  = '0;
    adc_dovf = 1'b0;
    cycle_no = 0;
    last_cnv = 0;
    last_latency = 0;
    cnv_seen     = 0;
    gate_cycles  = 0;
    valid_seen   = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = 32'hfe3d_0e0a;
    test_name    = "reset";

    repeat (10) @(posedge s_axi_aclk);
    #drive_delay;
    reset = 1'b0;

    // 1: outputs idle and registers at reset values
    start_test("reset state");
    repeat (2 * default_eff) @(posedge s_axi_aclk);
    if (cnv_seen != 0) report_mismatch("cnv pulses", 0, cnv_seen);
    if (gate_cycles != 0) report_mismatch("clk_gate cycles", 0, gate_cycles);
    if (valid_seen != 0) report_mismatch("adc_valid pulses", 0, valid_seen);
    read_reg(addr_control, rd_word);
    if (rd_word !== 32'h0) report_mismatch("control", 0, rd_word);
    read_reg(addr_period, rd_word);
    if (rd_word !== default_period) report_mismatch("period", default_period, rd_word);
    read_reg(addr_status, rd_word);
    if (rd_word !== 32'h0) report_mismatch("status", 0, rd_word);
    read_reg(addr_count, rd_word);
    if (rd_word !== 32'h0) report_mismatch("count", 0, rd_word);
    finish_test();

    // 2: write and read back, only bit 0 of control is stored
    start_test("register access");
    write_reg(addr_period, 32'h0000_0155);
    read_reg(addr_period, rd_word);
    if (rd_word !== 32'h0000_0155) report_mismatch("period", 32'h155, rd_word);
    write_reg(addr_control, 32'hffff_fffe);
    read_reg(addr_control, rd_word);
    if (rd_word !== 32'h0) report_mismatch("control", 0, rd_word);
    read_reg(4'h2, rd_word);
    if (rd_word !== 32'h0) report_mismatch("unused address", 0, rd_word);
    write_reg(addr_period, default_period);
    read_reg(addr_period, rd_word);
    if (rd_word !== default_period) report_mismatch("period", default_period, rd_word);
    finish_test();

    // 3: twenty samples, values checked by the monitor
    start_test("sample stream");
    write_reg(addr_control, 32'h1);
    read_reg(addr_control, rd_word);
    if (rd_word !== 32'h1) report_mismatch("control", 1, rd_word);
    wait_samples(20, 25 * default_eff);
    finish_test();

    // 4: cnv spacing, clamp and cnv to valid latency
    start_test("timing");
    wait_cnv(t0);
    wait_cnv(t1);
    if (t1 - t0 != default_eff) report_mismatch("cnv spacing", default_eff, t1 - t0);
    write_reg(addr_period, 32'd5);
    wait_cnv(t0);
    wait_cnv(t1);
    if (t1 - t0 != min_period) report_mismatch("clamped cnv spacing", min_period, t1 - t0);
    wait_samples(cnv_seen, cnv_timeout);
    if (last_latency != conv_cycles + bits_per_lane) begin
      report_mismatch("cnv to valid", conv_cycles + bits_per_lane, last_latency);
    end
    // every finished conversion had a gate window of bits_per_lane cycles
    if (gate_cycles != valid_seen * bits_per_lane) begin
      report_mismatch("clk_gate cycles", valid_seen * bits_per_lane, gate_cycles);
    end
    finish_test();

    // 5: sticky overflow at random points, then sample count
    start_test("overflow and count");
    repeat (3) begin
      gap = 1 + ($unsigned($random(seed)) % 16);
      repeat (gap) @(posedge s_axi_aclk);
      #drive_delay;
      adc_dovf = 1'b1;
      @(posedge s_axi_aclk);
      #drive_delay;
      adc_dovf = 1'b0;
      read_reg(addr_status, rd_word);
      if (rd_word !== 32'h1) report_mismatch("status after overflow", 1, rd_word);
      write_reg(addr_status, 32'h1);
      read_reg(addr_status, rd_word);
      if (rd_word !== 32'h0) report_mismatch("status after clear", 0, rd_word);
    end
    stop_and_drain();
    read_reg(addr_count, rd_word);
    if (rd_word !== valid_seen) report_mismatch("count", valid_seen, rd_word);
    finish_test();

    // 6: disable inside a conversion
    start_test("disable");
    write_reg(addr_control, 32'h1);
    wait_cnv(t0);
    cnv_mark = cnv_seen;
    repeat (conv_cycles) @(posedge s_axi_aclk);
    stop_and_drain();
    repeat (3 * min_period) @(posedge s_axi_aclk);
    #drive_delay;
    if (cnv_seen != cnv_mark) report_mismatch("cnv after disable", 0, cnv_seen - cnv_mark);
    read_reg(addr_count, rd_word);
    if (rd_word !== valid_seen) report_mismatch("count", valid_seen, rd_word);
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
design/adc_if_pkg.sv
design/adc_cnv_timer.sv
design/adc_lane_deser.sv
design/adc_ctrl_regs.sv
design/adc_capture_top.sv
testbench/adc_model.sv
testbench/adc_capture_tb.sv
